// File: compile.f
hw/timer_pkg.sv
hw/bcd_down_digit.sv
hw/tick_prescaler.sv
hw/mmss_countdown.sv
hw/timer_regs.sv
hw/timer_top.sv
bench/timer_checker.sv
bench/timer_tb.sv

// File: bench/timer_tb.sv
`timescale 1ns/1ps

module timer_tb
    import timer_pkg::*;
();

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    cmd_word_t cmd;
    logic      cmd_credit;
    mmss_t     display;
    logic      finished;
    logic      running;
    int        chk_errors;
    int        stim_errors;
    int        credits;
    int        credit_pulses;
    int        limit;
    int        run_div;
    int        burst_div [CMD_DEPTH];
    int        rand_digit [4];
    logic [31:0] lfsr_state;

    timer_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_credit(cmd_credit),
        .display   (display),
        .finished  (finished),
        .running   (running)
    );

    timer_checker u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .display    (display),
        .finished   (finished),
        .running    (running),
        .error_count(chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ########################################
    // helpers
    // ########################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};                  // one step per bit.
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic cmd_word_t digit_cmd(input int d);
        cmd_word_t w;
        w = '0;
        w.op = CMD_DIGIT;
        w.payload.digit.value = DIGIT_W'(d);
        return w;
    endfunction

    function automatic cmd_word_t divisor_cmd(input cmd_op_e op, input int p);
        cmd_word_t w;
        w.op = op;
        w.payload.prescale = PRESCALE_W'(p);
        return w;
    endfunction

    task automatic step_cycle();
        @(negedge clk);
        cmd_valid = 1'b0;
        if (cmd_credit === 1'b1) begin
            credits++;
            credit_pulses++;
            if (credits > CMD_DEPTH) begin
                stim_errors++;
                $display("%0t: more credits came back than commands were sent", $time);
            end
        end
    endtask

    task automatic send_cmd(input cmd_word_t w);
        while (credits == 0) step_cycle();
        cmd_valid = 1'b1;
        cmd = w;
        credits--;
        step_cycle();
    endtask

    task automatic drain_credits();
        while (credits != CMD_DEPTH) step_cycle();
    endtask

    task automatic wait_done();
        while (!(finished === 1'b1 && running === 1'b0)) step_cycle();
    endtask

    task automatic run_watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("timeout after %0d cycles, the countdown never completed", cycles);
        $display("Simulation failed");
        $finish;
    endtask

    // ########################################
    // stimulus
    // ########################################

    initial begin
        rst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        stim_errors = 0;
        credits = CMD_DEPTH;
        lfsr_state = 32'hf284;
        rand_digit[0] = 6 + int'(rand_bits(2));            // lands in min tens, saturates.
        for (int i = 1; i < 4; i++) rand_digit[i] = int'(rand_bits(4)) % 10;
        for (int i = 0; i < CMD_DEPTH; i++) burst_div[i] = 1 + int'(rand_bits(3)) % 7;
        run_div = burst_div[CMD_DEPTH-1];
        // loaded seconds of the random run, then the 10:03 run at divisor 1.
        limit = 5 * 600 + rand_digit[1] * 60 + (rand_digit[2] > 5 ? 5 : rand_digit[2]) * 10;
        limit = 2 * ((limit + rand_digit[3] + 2) * run_div + (603 + 2) + 24 * 40);
        fork
            run_watchdog(limit);
        join_none

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) step_cycle();

        credit_pulses = 0;
        for (int i = 0; i < CMD_DEPTH; i++) send_cmd(divisor_cmd(CMD_PRESCALE, burst_div[i]));
        drain_credits();
        repeat (CMD_DEPTH) step_cycle();                   // room for a stray extra pulse.
        if (credit_pulses != CMD_DEPTH) begin
            stim_errors++;
            $display("[FAIL] %0t credit_pulses expected %0d got %0d", $time, CMD_DEPTH,
                     credit_pulses);
        end

        for (int i = 0; i < 4; i++) send_cmd(digit_cmd(rand_digit[i]));
        send_cmd(divisor_cmd(CMD_START, 0));
        drain_credits();
        repeat (3 * run_div + 1) step_cycle();
        send_cmd(digit_cmd(7));                            // dropped while running.
        send_cmd(divisor_cmd(CMD_STOP, 0));
        drain_credits();
        repeat (20) step_cycle();
        send_cmd(divisor_cmd(CMD_START, 0));
        wait_done();
        send_cmd(divisor_cmd(CMD_START, 0));               // ignored at 00:00.
        drain_credits();
        repeat (4) step_cycle();

        // 10:03 crosses the 10:00 borrow.
        send_cmd(divisor_cmd(CMD_PRESCALE, 1));
        send_cmd(digit_cmd(1));
        send_cmd(digit_cmd(0));
        send_cmd(digit_cmd(0));
        send_cmd(digit_cmd(3));
        send_cmd(divisor_cmd(CMD_START, 0));
        drain_credits();
        wait_done();
        repeat (2) step_cycle();

        $display("errors: %0d from checker, %0d from stimulus", chk_errors, stim_errors);
        if (chk_errors == 0 && stim_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: bench/timer_checker.sv
`timescale 1ns/1ps

module timer_checker
    import timer_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  cmd_word_t cmd,
    input  logic      cmd_credit,
    input  mmss_t     display,
    input  logic      finished,
    input  logic      running,
    output int        error_count
);

    mmss_t                 exp_disp;
    logic                  exp_run;
    logic                  exp_credit;
    logic [PRESCALE_W-1:0] exp_div;
    int                    since;                          // edges since run rose or last tick.
    cmd_word_t             pend_q[$];
    logic                  cap_rst;
    logic                  cap_valid;
    cmd_word_t             cap_cmd;
    logic                  seen = 1'b0;

    // ########################################
    // reference functions
    // ########################################

    function automatic logic [DIGIT_W-1:0] clamp(input logic [DIGIT_W-1:0] v, input int top);
        return (v > top) ? DIGIT_W'(top) : v;
    endfunction

    function automatic mmss_t shift_in(input mmss_t d, input logic [DIGIT_W-1:0] v);
        mmss_t r;
        r.min_tens = clamp(d.min_unit, 5);                 // tens places stop at 5.
        r.min_unit = clamp(d.sec_tens, 9);
        r.sec_tens = clamp(d.sec_unit, 5);
        r.sec_unit = clamp(v, 9);
        return r;
    endfunction

    function automatic int to_secs(input mmss_t d);
        return d.min_tens * 600 + d.min_unit * 60 + d.sec_tens * 10 + d.sec_unit;
    endfunction

    function automatic mmss_t bcd_dec(input mmss_t d);
        int    s;
        mmss_t r;
        s = to_secs(d);
        if (s > 0) begin
            s = s - 1;
        end
        r.min_tens = DIGIT_W'(s / 600);
        r.min_unit = DIGIT_W'((s / 60) % 10);
        r.sec_tens = DIGIT_W'((s % 60) / 10);
        r.sec_unit = DIGIT_W'(s % 10);
        return r;
    endfunction

    function automatic logic all_zero(input mmss_t d);
        return to_secs(d) == 0;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // ########################################
    // model and compare
    // ########################################

    initial error_count = 0;

    // inputs change on falling edges, so grab them here.
    always @(posedge clk) begin
        cap_rst   <= rst_n;
        cap_valid <= cmd_valid;
        cap_cmd   <= cmd;
        seen      <= 1'b1;
    end

    always @(negedge clk) begin : model_step
        logic      fin_pre;
        logic      run_pre;
        logic      tick;
        logic      exec;
        int        eff;
        cmd_word_t c;
        if (seen && !cap_rst) begin
            exp_disp   = '0;
            exp_run    = 1'b0;
            exp_credit = 1'b0;
            exp_div    = PRESCALE_W'(1);
            since      = 0;
            pend_q.delete();
        end else if (seen) begin
            fin_pre = all_zero(exp_disp);
            run_pre = exp_run;
            eff     = (exp_div == 0) ? 1 : int'(exp_div);
            c       = '0;
            exec    = (pend_q.size() > 0);                 // oldest entry runs now.
            if (cap_valid && pend_q.size() == CMD_DEPTH) begin
                error_count++;
                $display("%0t: command sent while the command FIFO was full", $time);
            end
            if (exec) begin
                c = pend_q.pop_front();
            end
            if (cap_valid && pend_q.size() < CMD_DEPTH) begin
                pend_q.push_back(cap_cmd);
            end
            tick = 1'b0;
            if (run_pre) begin
                since++;
                tick = (since == eff);
                if (tick) begin
                    since = 0;
                end
            end
            if (tick && !fin_pre) begin
                exp_disp = bcd_dec(exp_disp);
            end
            if (exec && c.op == CMD_DIGIT && !run_pre) begin
                exp_disp = shift_in(exp_disp, c.payload.digit.value);
            end
            if (exec && c.op == CMD_PRESCALE) begin
                exp_div = c.payload.prescale;
            end
            if (fin_pre) begin
                exp_run = 1'b0;
            end else if (exec && c.op == CMD_START) begin
                exp_run = 1'b1;
            end else if (exec && c.op == CMD_STOP) begin
                exp_run = 1'b0;
            end
            if (!run_pre && exp_run) begin
                since = 0;                                 // fresh start.
            end
            exp_credit = exec;
        end
        if (seen) begin
            check_value("display", display, exp_disp);
            check_value("finished", finished, all_zero(exp_disp));
            check_value("running", running, exp_run);
            check_value("cmd_credit", cmd_credit, exp_credit);
        end
    end

endmodule

// File: hw/timer_top.sv
`timescale 1ns/1ps

module timer_top
    import timer_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  cmd_word_t cmd,
    output logic      cmd_credit,
    output mmss_t     display,
    output logic      finished,
    output logic      running
);

    logic                  run;
    logic [PRESCALE_W-1:0] prescale;
    logic                  load_en;
    logic [DIGIT_W-1:0]    load_digit;
    logic                  tick;

    timer_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .finished  (finished),
        .cmd_credit(cmd_credit),
        .run       (run),
        .prescale  (prescale),
        .load_en   (load_en),
        .load_digit(load_digit)
    );

    tick_prescaler u_prescaler (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .prescale(prescale),
        .tick    (tick)
    );

    mmss_countdown u_countdown (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .load_en   (load_en),
        .load_digit(load_digit),
        .display   (display),
        .finished  (finished)
    );

    assign running = run;

endmodule

// File: hw/timer_regs.sv
`timescale 1ns/1ps

module timer_regs
    import timer_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  cmd_word_t             cmd,
    input  logic                  finished,
    output logic                  cmd_credit,
    output logic                  run,
    output logic [PRESCALE_W-1:0] prescale,
    output logic                  load_en,
    output logic [DIGIT_W-1:0]    load_digit
);

    cmd_word_t            fifo_mem [CMD_DEPTH];
    cmd_word_t            head;
    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_CNT_W-1:0] fill;
    logic                 full;
    logic                 empty;
    logic                 push;
    logic                 pop;

    // ########################################
    // command FIFO
    // ########################################

    assign full  = (fill == CMD_CNT_W'(CMD_DEPTH));
    assign empty = (fill == '0);
    assign push  = cmd_valid & ~full;                     // overflow is dropped.
    assign pop   = ~empty;                                // one command per cycle.
    assign head  = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == CMD_PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == CMD_PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // ########################################
    // decode
    // ########################################

    // digits are ignored while counting.
    assign load_en    = pop & (head.op == CMD_DIGIT) & ~run;
    assign load_digit = head.payload.digit.value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prescale <= PRESCALE_RESET;
        end else if (pop && head.op == CMD_PRESCALE) begin
            prescale <= head.payload.prescale;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_credit <= 1'b0;
            run        <= 1'b0;
        end else begin
            cmd_credit <= pop;                            // every pop returns a credit.
            if (finished) begin
                run <= 1'b0;                              // also blocks a start at 00:00.
            end else if (pop && head.op == CMD_START) begin
                run <= 1'b1;
            end else if (pop && head.op == CMD_STOP) begin
                run <= 1'b0;
            end
        end
    end

    // ########################################
    // checks
    // ########################################

    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_valid |-> !full
    ) else $error("command sent without credit, FIFO full");

    // run must drop on the edge after the display hits 00:00.
    a_stop_at_zero : assert property (
        @(posedge clk) disable iff (!rst_n)
        finished && $past(finished) |-> !run
    ) else $error("still running one cycle after finish");

endmodule

// File: hw/mmss_countdown.sv
`timescale 1ns/1ps

module mmss_countdown
    import timer_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tick,
    input  logic               load_en,
    input  logic [DIGIT_W-1:0] load_digit,
    output mmss_t              display,
    output logic               finished
);

    // index 0 is the seconds units, index 3 the minutes tens.
    logic [NUM_DIGITS-1:0][DIGIT_W-1:0] cnt;
    logic [NUM_DIGITS-1:0][DIGIT_W-1:0] load_in;
    logic [NUM_DIGITS-1:0]              dec_in;
    logic [NUM_DIGITS-1:0]              borrow_out;
    logic [NUM_DIGITS-1:0]              zero_f;
    logic                               step;

    // ########################################
    // chain wiring
    // ########################################

    // no step once at 00:00, even if a tick is still in flight.
    assign step = tick & ~finished;

    assign dec_in  = {borrow_out[NUM_DIGITS-2:0], step};  // borrow ripple.
    assign load_in = {cnt[NUM_DIGITS-2:0], load_digit};   // shift toward min tens.

    // one units digit and one tens digit per pair.
    for (genvar p = 0; p < NUM_DIGITS / 2; p++) begin : g_pair
        bcd_down_digit #(
            .MODULUS(10)
        ) u_unit (
            .clk       (clk),
            .rst_n     (rst_n),
            .dec       (dec_in[2*p]),
            .load      (load_en),
            .load_value(load_in[2*p]),
            .count     (cnt[2*p]),
            .borrow    (borrow_out[2*p]),
            .zero      (zero_f[2*p])
        );

        bcd_down_digit #(
            .MODULUS(6)
        ) u_tens (
            .clk       (clk),
            .rst_n     (rst_n),
            .dec       (dec_in[2*p+1]),
            .load      (load_en),
            .load_value(load_in[2*p+1]),
            .count     (cnt[2*p+1]),
            .borrow    (borrow_out[2*p+1]),
            .zero      (zero_f[2*p+1])
        );
    end

    assign display  = mmss_t'(cnt);
    assign finished = &zero_f;

    // ########################################
    // checks
    // ########################################

    // loads only happen while stopped, ticks only while running.
    a_tick_vs_load : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(tick && load_en)
    ) else $error("tick and load_en high together");

endmodule

// File: hw/tick_prescaler.sv
`timescale 1ns/1ps

module tick_prescaler
    import timer_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  run,
    input  logic [PRESCALE_W-1:0] prescale,
    output logic                  tick
);

    logic [PRESCALE_W-1:0] cnt;
    logic [PRESCALE_W-1:0] cur;
    logic [PRESCALE_W-1:0] div_eff;
    logic                  run_q;

    assign div_eff = (prescale == '0) ? PRESCALE_RESET : prescale;   // 0 acts as 1.

    // a fresh start counts from zero.
    assign cur = (run && !run_q) ? '0 : cnt;

    // >= so a shrunken divisor mid-run still fires.
    assign tick = run && (cur >= div_eff - 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt   <= '0;
            run_q <= 1'b0;
        end else begin
            run_q <= run;
            if (run) begin
                cnt <= tick ? '0 : cur + 1'b1;
            end                                           // held while stopped.
        end
    end

endmodule

// File: hw/bcd_down_digit.sv
`timescale 1ns/1ps

module bcd_down_digit
    import timer_pkg::*;
#(
    parameter int MODULUS = 10
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dec,
    input  logic               load,
    input  logic [DIGIT_W-1:0] load_value,
    output logic [DIGIT_W-1:0] count,
    output logic               borrow,
    output logic               zero
);

    localparam logic [DIGIT_W-1:0] TOP = DIGIT_W'(MODULUS - 1);

    logic [DIGIT_W-1:0] load_sat;

    // a 7 shifted into a tens place shows as 5.
    assign load_sat = (load_value > TOP) ? TOP : load_value;

    assign zero   = (count == '0);
    assign borrow = dec & zero;                           // next digit up steps too.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_sat;
        end else if (dec) begin
            if (zero) begin
                count <= TOP;                             // wrap.
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // ########################################
    // checks
    // ########################################

    a_count_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(count) < MODULUS
    ) else $error("bcd digit out of range: %0d (modulus %0d)", count, MODULUS);

endmodule

// File: hw/timer_pkg.sv
package timer_pkg;

    // ########################################
    // sizes
    // ########################################

    localparam int CMD_DEPTH  = 4;                        // also the starting credit count.
    localparam int CMD_PTR_W  = $clog2(CMD_DEPTH);
    localparam int CMD_CNT_W  = $clog2(CMD_DEPTH + 1);
    localparam int PRESCALE_W = 12;
    localparam int DIGIT_W    = 4;
    localparam int NUM_DIGITS = 4;                        // mm:ss.
    localparam int PAD_W      = PRESCALE_W - DIGIT_W;

    // divisor after reset, and the floor for a zero divisor.
    localparam logic [PRESCALE_W-1:0] PRESCALE_RESET = PRESCALE_W'(1);

    // ########################################
    // command word
    // ########################################

    typedef enum logic [1:0] {
        CMD_DIGIT    = 2'd0,                              // shift one digit in.
        CMD_PRESCALE = 2'd1,
        CMD_START    = 2'd2,
        CMD_STOP     = 2'd3
    } cmd_op_e;

    typedef struct packed {
        logic [PAD_W-1:0]   pad;
        logic [DIGIT_W-1:0] value;
    } digit_view_t;

    // same 12 bits, read by opcode.
    typedef union packed {
        digit_view_t           digit;
        logic [PRESCALE_W-1:0] prescale;
    } cmd_payload_u;

    typedef struct packed {
        cmd_op_e      op;
        cmd_payload_u payload;
    } cmd_word_t;

    // ########################################
    // display
    // ########################################

    typedef struct packed {
        logic [DIGIT_W-1:0] min_tens;
        logic [DIGIT_W-1:0] min_unit;
        logic [DIGIT_W-1:0] sec_tens;
        logic [DIGIT_W-1:0] sec_unit;
    } mmss_t;

endpackage
